/* irq_ctrl_top.f */
+incdir+include
rtl/tlul_lite_pkg.sv
rtl/irq_ctrl_reg_pkg.sv
rtl/irq_ctrl_reg_top.sv
rtl/irq_ctrl_core.sv
rtl/irq_ctrl_top.sv
dv/tb_irq_ctrl.sv

/* Makefile */
# Verilator build and run for the interrupt controller
# Any variable below can be overridden, e.g. make SEED=7 LOG=run.log

TOP       ?= tb_irq_ctrl
RTL_TOP   ?= irq_ctrl_top
SEED      ?= 36
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= irq_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
EXTRA     ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the exit status of the binary
run: build
	-$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "simulation passed, log in $(LOG)"; \
	else \
		echo "simulation failed, log in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert $(EXTRA) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --assert $(EXTRA) --top-module $(RTL_TOP) \
		+incdir+include rtl/tlul_lite_pkg.sv rtl/irq_ctrl_reg_pkg.sv \
		rtl/irq_ctrl_reg_top.sv rtl/irq_ctrl_core.sv rtl/irq_ctrl_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_irq_ctrl.sv */
`include "irq_ctrl_consts.svh"

module tb_irq_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYC = 20;

	logic                   clk_i;
	logic                   rst_ni;
	logic [`IRQ_N-1:0]      irq_i;
	logic                   irq_en_o;
	tlul_lite_pkg::tl_h2d_t tl_i;
	tlul_lite_pkg::tl_d2h_t tl_o;

	int seed;
	int errors;
	int checks;
	bit chk_en;

	// reference model
	logic [`IRQ_N-1:0]  mask_m;
	logic               all_en_m;
	logic               test_m;
	logic [`IRQ_N-1:0]  test_irq_m;
	logic [`IRQ_N-1:0]  irq_h1;     // irq_i as of the last edge
	logic [`IRQ_N-1:0]  masked_m;   // selected lines and mask as of the last edge
	logic               wr_pend;    // good write lands on the next edge
	logic [`IRQ_AW-1:0] wr_addr;
	logic [31:0]        wr_data;

	irq_ctrl_top DUT (
		.clk_i,
		.rst_ni,
		.irq_i,
		.irq_en_o,
		.tl_i,
		.tl_o
	);

	initial clk_i = 1'b0;
	always #20 clk_i = ~clk_i;

	always @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mask_m     <= '0;
			all_en_m   <= 1'b0;
			test_m     <= 1'b0;
			test_irq_m <= '0;
			irq_h1     <= '0;
			masked_m   <= '0;
		end else begin
			irq_h1   <= irq_i;
			masked_m <= (test_m ? test_irq_m : irq_i) & mask_m;
			if (wr_pend) begin
				case (wr_addr)
					`IRQ_CTRL_MASK_OFS:     mask_m <= wr_data[`IRQ_N-1:0];
					`IRQ_CTRL_MASK_SET_OFS: mask_m <= mask_m | wr_data[`IRQ_N-1:0];
					`IRQ_CTRL_MASK_CLR_OFS: mask_m <= mask_m & ~wr_data[`IRQ_N-1:0];
					`IRQ_CTRL_ALL_EN_OFS:   all_en_m <= wr_data[0];
					`IRQ_CTRL_TEST_OFS:     test_m <= wr_data[0];
					`IRQ_CTRL_TEST_IRQ_OFS: test_irq_m <= wr_data[`IRQ_N-1:0];
					default: ;
				endcase
			end
		end
	end

	// request line checked every cycle
	always @(negedge clk_i) begin
		if (chk_en) begin
			checks++;
			if (irq_en_o !== ((|masked_m) & all_en_m)) begin
				$display("Fail %0t: irq_en_o is %0b, expected %0b", $time, irq_en_o,
					(|masked_m) & all_en_m);
				errors++;
			end
		end
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [`IRQ_NO_W-1:0] lowest_pending(input logic [`IRQ_N-1:0] vec);
		logic [`IRQ_NO_W-1:0] idx;
		bit                   found;
		idx   = `IRQ_NO_W'(`IRQ_N);   // none pending
		found = 1'b0;
		for (int i = 0; i < `IRQ_N; i++) begin
			if (!found && vec[i]) begin
				idx   = `IRQ_NO_W'(i);
				found = 1'b1;
			end
		end
		return idx;
	endfunction

	function automatic bit is_bad_req(input bit is_put, input logic [`IRQ_AW-1:0] addr,
			input logic [3:0] be);
		if (!(addr inside {`IRQ_CTRL_MASK_OFS, `IRQ_CTRL_MASK_SET_OFS, `IRQ_CTRL_MASK_CLR_OFS,
				`IRQ_CTRL_STATUS_OFS, `IRQ_CTRL_IRQ_NO_OFS, `IRQ_CTRL_ALL_EN_OFS,
				`IRQ_CTRL_TEST_OFS, `IRQ_CTRL_TEST_IRQ_OFS})) begin
			return 1'b1;
		end
		if (is_put && (addr == `IRQ_CTRL_STATUS_OFS || addr == `IRQ_CTRL_IRQ_NO_OFS)) begin
			return 1'b1;
		end
		return is_put && be != 4'hF;
	endfunction

	function automatic logic [31:0] read_value(input logic [`IRQ_AW-1:0] addr);
		case (addr)
			`IRQ_CTRL_MASK_OFS:     return 32'(mask_m);
			`IRQ_CTRL_STATUS_OFS:   return 32'(irq_h1);
			`IRQ_CTRL_IRQ_NO_OFS:   return 32'(lowest_pending(masked_m));
			`IRQ_CTRL_ALL_EN_OFS:   return 32'(all_en_m);
			`IRQ_CTRL_TEST_OFS:     return 32'(test_m);
			`IRQ_CTRL_TEST_IRQ_OFS: return 32'(test_irq_m);
			default:                return '0;   // set/clear aliases and unmapped
		endcase
	endfunction

	// starts and ends on a falling edge
	task automatic send_req(input bit is_put, input logic [`IRQ_AW-1:0] addr,
			input logic [3:0] be, input logic [31:0] data, output bit ok);
		int waited;
		waited = 0;
		ok     = 1'b1;
		tl_i.a_valid   = 1'b1;
		tl_i.a_opcode  = tlul_lite_pkg::Get;
		if (is_put) begin
			tl_i.a_opcode = tlul_lite_pkg::PutFullData;
		end
		tl_i.a_address = addr;
		tl_i.a_mask    = be;
		tl_i.a_data    = data;
		#1;
		while (!tl_o.a_ready && waited < TIMEOUT_CYC) begin
			@(negedge clk_i);
			#1;
			waited++;
		end
		if (!tl_o.a_ready) begin
			$display("a_ready stayed low for %0d cycles at %0t, request dropped",
				TIMEOUT_CYC, $time);
			errors++;
			ok = 1'b0;
			@(negedge clk_i);
			tl_i.a_valid = 1'b0;
			return;
		end
		wr_pend = is_put && !is_bad_req(is_put, addr, be);
		wr_addr = addr;
		wr_data = data;
		@(posedge clk_i);   // accepted here
		@(negedge clk_i);
		wr_pend      = 1'b0;
		tl_i.a_valid = 1'b0;
	endtask

	task automatic wait_rsp(output logic [31:0] data, output logic err, output bit ok);
		int waited;
		waited = 0;
		while (!tl_o.d_valid && waited < TIMEOUT_CYC) begin
			@(negedge clk_i);
			waited++;
		end
		ok = tl_o.d_valid;
		if (!ok) begin
			$display("no response within %0d cycles at %0t", TIMEOUT_CYC, $time);
			errors++;
		end
		data = tl_o.d_data;
		err  = tl_o.d_error;
	endtask

	task automatic check_read(input logic [`IRQ_AW-1:0] addr);
		logic [31:0] exp_data;
		logic        exp_err;
		logic [31:0] data;
		logic        err;
		bit          ok;
		exp_err  = is_bad_req(1'b0, addr, 4'hF);
		exp_data = read_value(addr);
		send_req(1'b0, addr, 4'hF, '0, ok);
		if (ok) wait_rsp(data, err, ok);
		if (ok) begin
			checks++;
			if (err !== exp_err || data !== exp_data) begin
				$display("Fail %0t: read 0x%02h gave 0x%08h err %0b, expected 0x%08h err %0b",
					$time, addr, data, err, exp_data, exp_err);
				errors++;
			end
		end
	endtask

	task automatic check_write(input logic [`IRQ_AW-1:0] addr, input logic [3:0] be,
			input logic [31:0] wdata);
		logic        exp_err;
		logic [31:0] data;
		logic        err;
		bit          ok;
		exp_err = is_bad_req(1'b1, addr, be);
		send_req(1'b1, addr, be, wdata, ok);
		if (ok) wait_rsp(data, err, ok);
		if (ok) begin
			checks++;
			if (err !== exp_err || data !== '0) begin
				$display("Fail %0t: write 0x%02h mask %h gave err %0b data 0x%08h, expected err %0b",
					$time, addr, be, err, data, exp_err);
				errors++;
			end
		end
	endtask

	// read with d_ready held low for a while
	task automatic check_stall(input logic [`IRQ_AW-1:0] addr, input int hold);
		logic [31:0] exp_data;
		int          waited;
		bit          ok;
		waited = 0;
		while (tl_o.d_valid && waited < TIMEOUT_CYC) begin   // let the last response retire
			@(negedge clk_i);
			waited++;
		end
		exp_data     = read_value(addr);
		tl_i.d_ready = 1'b0;
		send_req(1'b0, addr, 4'hF, '0, ok);
		if (ok) begin
			checks++;
			if (!tl_o.d_valid) begin
				$display("no response after an accepted read at %0t", $time);
				errors++;
			end else if (tl_o.d_data !== exp_data) begin
				$display("Fail %0t: stalled read 0x%02h gave 0x%08h, expected 0x%08h",
					$time, addr, tl_o.d_data, exp_data);
				errors++;
			end
			repeat (hold) begin
				@(negedge clk_i);
				checks++;
				if (!tl_o.d_valid || tl_o.d_data !== exp_data || tl_o.a_ready) begin
					$display("Fail %0t: response moved under back-pressure (valid %0b ready %0b)",
						$time, tl_o.d_valid, tl_o.a_ready);
					errors++;
				end
			end
		end
		tl_i.d_ready = 1'b1;
		@(negedge clk_i);
		checks++;
		if (tl_o.d_valid) begin
			$display("Fail %0t: response not retired after d_ready rose", $time);
			errors++;
		end
	endtask

	initial begin
		logic [`IRQ_AW-1:0] addr;
		logic [3:0]         be;
		int                 kind;
		seed     = 36;
		errors   = 0;
		checks   = 0;
		chk_en   = 1'b0;
		rst_ni   = 1'b0;
		irq_i    = '0;
		tl_i     = tlul_lite_pkg::TL_H2D_IDLE;
		wr_pend  = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		repeat (3) @(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);
		chk_en = 1'b1;

		// reset values
		for (int a = 0; a < 8; a++) begin
			check_read(`IRQ_AW'(a * 4));
		end

		// mask write, set and clear
		for (int i = 0; i < 30; i++) begin
			kind = rand_below(3);
			check_write(`IRQ_AW'(kind * 4), 4'hF, $random(seed));
			check_read(`IRQ_CTRL_MASK_OFS);
			if (i % 5 == 0) check_read(`IRQ_CTRL_MASK_SET_OFS);
			if (i % 5 == 1) check_read(`IRQ_CTRL_MASK_CLR_OFS);
		end

		// status, priority and request line
		check_write(`IRQ_CTRL_ALL_EN_OFS, 4'hF, 32'h1);
		for (int i = 0; i < 40; i++) begin
			irq_i = `IRQ_N'($random(seed));
			if (i % 4 == 0) check_write(`IRQ_CTRL_MASK_OFS, 4'hF, $random(seed));
			if (i % 7 == 3) check_write(`IRQ_CTRL_ALL_EN_OFS, 4'hF, $random(seed));
			repeat (2) @(negedge clk_i);
			check_read(`IRQ_CTRL_STATUS_OFS);
			check_read(`IRQ_CTRL_IRQ_NO_OFS);
			check_read(`IRQ_CTRL_ALL_EN_OFS);
		end

		// test mode
		check_write(`IRQ_CTRL_ALL_EN_OFS, 4'hF, 32'h1);
		check_write(`IRQ_CTRL_TEST_OFS, 4'hF, 32'h1);
		for (int i = 0; i < 20; i++) begin
			check_write(`IRQ_CTRL_TEST_IRQ_OFS, 4'hF, $random(seed));
			irq_i = `IRQ_N'($random(seed));
			repeat (2) @(negedge clk_i);
			check_read(`IRQ_CTRL_STATUS_OFS);
			check_read(`IRQ_CTRL_IRQ_NO_OFS);
			check_read(`IRQ_CTRL_TEST_IRQ_OFS);
		end
		check_write(`IRQ_CTRL_TEST_OFS, 4'hF, 32'h0);

		// error responses leave the state alone
		for (int i = 0; i < 24; i++) begin
			kind = rand_below(3);
			case (kind)
				0: begin
					addr    = `IRQ_AW'($random(seed));
					addr[5] = 1'b1;   // above the register map
					check_read(addr);
					check_write(addr, 4'hF, $random(seed));
				end
				1: begin
					addr = rand_below(2) ? `IRQ_CTRL_STATUS_OFS : `IRQ_CTRL_IRQ_NO_OFS;
					check_write(addr, 4'hF, $random(seed));
					check_read(addr);
				end
				default: begin
					addr = `IRQ_AW'(rand_below(8) * 4);
					be   = 4'($random(seed));
					if (be == 4'hF) be = 4'h7;
					check_write(addr, be, $random(seed));
				end
			endcase
			check_read(`IRQ_CTRL_MASK_OFS);
			check_read(`IRQ_CTRL_ALL_EN_OFS);
			check_read(`IRQ_CTRL_TEST_OFS);
			check_read(`IRQ_CTRL_TEST_IRQ_OFS);
		end

		// back-pressure
		for (int i = 0; i < 10; i++) begin
			check_write(`IRQ_CTRL_MASK_OFS, 4'hF, $random(seed));
			irq_i = `IRQ_N'($random(seed));
			addr  = `IRQ_AW'(rand_below(8) * 4);
			check_stall(addr, 1 + rand_below(6));
		end

		repeat (2) @(negedge clk_i);
		chk_en = 1'b0;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* rtl/irq_ctrl_top.sv */
`include "irq_ctrl_consts.svh"

module irq_ctrl_top (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic [`IRQ_N-1:0]      irq_i,     // level sensitive
	output logic                   irq_en_o,
	input  tlul_lite_pkg::tl_h2d_t tl_i,
	output tlul_lite_pkg::tl_d2h_t tl_o
);

	irq_ctrl_reg_pkg::irq_ctrl_reg2hw_t reg2hw;   // software to core
	irq_ctrl_reg_pkg::irq_ctrl_hw2reg_t hw2reg;   // core to software

	irq_ctrl_reg_top u_reg_top (
		.clk_i,
		.rst_ni,
		.tl_i,
		.tl_o,
		.reg2hw_o (reg2hw),
		.hw2reg_i (hw2reg)
	);

	irq_ctrl_core #(
		.N (`IRQ_N)
	) u_core (
		.clk_i,
		.rst_ni,
		.irq_i,
		.reg2hw_i (reg2hw),
		.hw2reg_o (hw2reg),
		.irq_en_o
	);

endmodule

/* rtl/irq_ctrl_core.sv */
`include "irq_ctrl_consts.svh"

module irq_ctrl_core #(
	parameter int N = `IRQ_N
) (
	input  logic                               clk_i,
	input  logic                               rst_ni,
	input  logic [N-1:0]                       irq_i,
	input  irq_ctrl_reg_pkg::irq_ctrl_reg2hw_t reg2hw_i,
	output irq_ctrl_reg_pkg::irq_ctrl_hw2reg_t hw2reg_o,
	output logic                               irq_en_o
);

	// wide enough to hold N itself
	localparam int NoW = $clog2(N + 1);

	logic [N-1:0]   mask;
	logic [N-1:0]   test_irq;
	logic [N-1:0]   irq_sel;
	logic [N-1:0]   status_q;
	logic [N-1:0]   masked_q;
	logic [NoW-1:0] irq_no;

	// bring the register fields to the core width
	assign mask     = N'(reg2hw_i.mask);
	assign test_irq = N'(reg2hw_i.test_irq);

	// test mode swaps in the software pattern
	assign irq_sel = reg2hw_i.test ? test_irq : irq_i;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			status_q <= '0;
			masked_q <= '0;
		end else begin
			status_q <= irq_i;   // always the physical lines
			masked_q <= irq_sel & mask;
		end
	end

	// lowest set bit wins, scan from the top down
	always_comb begin
		irq_no = NoW'(N);
		for (int i = N - 1; i >= 0; i--) begin
			if (masked_q[i]) begin
				irq_no = NoW'(i);
			end
		end
	end

	assign irq_en_o = (|masked_q) & reg2hw_i.all_en;

	assign hw2reg_o.status = `IRQ_N'(status_q);
	assign hw2reg_o.irq_no = `IRQ_NO_W'(irq_no);

	a_en_valid_idx: assert property (@(posedge clk_i) disable iff (!rst_ni)
		irq_en_o |-> (irq_no < NoW'(N)));

	a_none_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(irq_no == NoW'(N)) == (masked_q == '0));

endmodule

/* rtl/irq_ctrl_reg_top.sv */
`include "irq_ctrl_consts.svh"

module irq_ctrl_reg_top (
	input  logic                               clk_i,
	input  logic                               rst_ni,
	input  tlul_lite_pkg::tl_h2d_t             tl_i,
	output tlul_lite_pkg::tl_d2h_t             tl_o,
	output irq_ctrl_reg_pkg::irq_ctrl_reg2hw_t reg2hw_o,
	input  irq_ctrl_reg_pkg::irq_ctrl_hw2reg_t hw2reg_i
);

	irq_ctrl_reg_pkg::irq_ctrl_reg2hw_t regs_q;

	logic        a_ready;
	logic        accept;
	logic        is_put;
	logic        is_get;
	logic        req_err;
	logic [31:0] rdata;
	logic        wr_ok;

	logic        d_valid_q;
	logic        d_error_q;
	logic [31:0] d_data_q;

	// one transaction in flight; a stalled response blocks new requests
	assign a_ready = ~d_valid_q | tl_i.d_ready;
	assign accept  = tl_i.a_valid & a_ready;
	assign is_put  = tl_i.a_opcode == tlul_lite_pkg::PutFullData;
	assign is_get  = tl_i.a_opcode == tlul_lite_pkg::Get;

	// address decode and read mux
	always_comb begin
		rdata   = '0;
		req_err = 1'b0;
		case (tl_i.a_address)
			`IRQ_CTRL_MASK_OFS:     rdata = 32'(regs_q.mask);
			`IRQ_CTRL_MASK_SET_OFS: rdata = '0;   // write-only alias
			`IRQ_CTRL_MASK_CLR_OFS: rdata = '0;
			`IRQ_CTRL_STATUS_OFS: begin
				rdata   = 32'(hw2reg_i.status);
				req_err = is_put;   // read only
			end
			`IRQ_CTRL_IRQ_NO_OFS: begin
				rdata   = 32'(hw2reg_i.irq_no);
				req_err = is_put;
			end
			`IRQ_CTRL_ALL_EN_OFS:   rdata = 32'(regs_q.all_en);
			`IRQ_CTRL_TEST_OFS:     rdata = 32'(regs_q.test);
			`IRQ_CTRL_TEST_IRQ_OFS: rdata = 32'(regs_q.test_irq);
			default:                req_err = 1'b1;
		endcase
		// only full-word writes are supported
		if (is_put && tl_i.a_mask != 4'hF) begin
			req_err = 1'b1;
		end
		if (!is_put && !is_get) begin
			req_err = 1'b1;
		end
		if (req_err || is_put) begin
			rdata = '0;
		end
	end

	assign wr_ok = accept & is_put & ~req_err;

	// software registers, written on the acceptance edge
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			regs_q <= irq_ctrl_reg_pkg::REG2HW_RESET;
		end else if (wr_ok) begin
			regs_q.mask <= irq_ctrl_reg_pkg::mask_update(
				regs_q.mask, tl_i.a_data,
				tl_i.a_address == `IRQ_CTRL_MASK_OFS,
				tl_i.a_address == `IRQ_CTRL_MASK_SET_OFS,
				tl_i.a_address == `IRQ_CTRL_MASK_CLR_OFS);
			if (tl_i.a_address == `IRQ_CTRL_ALL_EN_OFS) begin
				regs_q.all_en <= tl_i.a_data[0];
			end
			if (tl_i.a_address == `IRQ_CTRL_TEST_OFS) begin
				regs_q.test <= tl_i.a_data[0];
			end
			if (tl_i.a_address == `IRQ_CTRL_TEST_IRQ_OFS) begin
				regs_q.test_irq <= tl_i.a_data[`IRQ_N-1:0];
			end
		end
	end

	// response valid and error
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			d_valid_q <= 1'b0;
			d_error_q <= 1'b0;
		end else if (accept) begin
			d_valid_q <= 1'b1;
			d_error_q <= req_err;
		end else if (tl_i.d_ready) begin
			d_valid_q <= 1'b0;   // retired
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			d_data_q <= rdata;
		end
	end

	assign tl_o.a_ready = a_ready;
	assign tl_o.d_valid = d_valid_q;
	assign tl_o.d_data  = d_data_q;
	assign tl_o.d_error = d_error_q;

	assign reg2hw_o = regs_q;

	// a stalled response must not move until the host takes it
	a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(tl_o.d_valid && !tl_i.d_ready)
		|=> (tl_o.d_valid && $stable(tl_o.d_data) && $stable(tl_o.d_error)));

	a_err_no_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(tl_o.d_valid && tl_o.d_error) |-> (tl_o.d_data == '0));

endmodule

/* rtl/irq_ctrl_reg_pkg.sv */
`include "irq_ctrl_consts.svh"

package irq_ctrl_reg_pkg;

	// software-written values going to the core
	typedef struct packed {
		logic [`IRQ_N-1:0] mask;
		logic              all_en;   // gates irq_en_o
		logic              test;     // 1 selects test_irq as input
		logic [`IRQ_N-1:0] test_irq;
	} irq_ctrl_reg2hw_t;

	// values produced by the core, read only from the bus
	typedef struct packed {
		logic [`IRQ_N-1:0]    status;   // sampled physical lines
		logic [`IRQ_NO_W-1:0] irq_no;   // lowest pending index, N if none
	} irq_ctrl_hw2reg_t;

	localparam irq_ctrl_reg2hw_t REG2HW_RESET = '{
		mask:     `IRQ_CTRL_MASK_RESVAL,
		all_en:   `IRQ_CTRL_ALL_EN_RESVAL,
		test:     `IRQ_CTRL_TEST_RESVAL,
		test_irq: `IRQ_CTRL_TEST_IRQ_RESVAL
	};

	// applies a mask write, set or clear on top of the current mask
	function automatic logic [`IRQ_N-1:0] mask_update(
		input logic [`IRQ_N-1:0] cur,
		input logic [31:0]       wdata,
		input logic              do_wr,
		input logic              do_set,
		input logic              do_clr
	);
		logic [`IRQ_N-1:0] nxt;
		nxt = cur;
		if (do_wr) nxt = wdata[`IRQ_N-1:0];
		if (do_set) nxt = cur | wdata[`IRQ_N-1:0];
		if (do_clr) nxt = cur & ~wdata[`IRQ_N-1:0];
		return nxt;
	endfunction

endpackage

/* rtl/tlul_lite_pkg.sv */
`include "irq_ctrl_consts.svh"

package tlul_lite_pkg;

	// encodings as in TileLink UL channel A
	typedef enum logic [2:0] {
		PutFullData = 3'h0,
		Get         = 3'h4
	} tl_opcode_e;

	// host to device, A channel request plus D channel ready
	typedef struct packed {
		logic             a_valid;
		tl_opcode_e       a_opcode;
		logic [`IRQ_AW-1:0] a_address;
		logic [3:0]       a_mask;   // byte lanes
		logic [31:0]      a_data;
		logic             d_ready;
	} tl_h2d_t;

	// device to host
	typedef struct packed {
		logic        a_ready;
		logic        d_valid;
		logic [31:0] d_data;
		logic        d_error;
	} tl_d2h_t;

	localparam tl_h2d_t TL_H2D_IDLE = '{
		a_valid:   1'b0,
		a_opcode:  Get,
		a_address: '0,
		a_mask:    '0,
		a_data:    '0,
		d_ready:   1'b1
	};

endpackage

/* include/irq_ctrl_consts.svh */
`ifndef IRQ_CTRL_CONSTS_SVH
`define IRQ_CTRL_CONSTS_SVH

// number of interrupt lines
`define IRQ_N 16
// one extra bit so the index can hold N itself
`define IRQ_NO_W ($clog2(`IRQ_N) + 1)
`define IRQ_AW 8

// byte offsets
`define IRQ_CTRL_MASK_OFS     8'h00
`define IRQ_CTRL_MASK_SET_OFS 8'h04
`define IRQ_CTRL_MASK_CLR_OFS 8'h08
`define IRQ_CTRL_STATUS_OFS   8'h0C
`define IRQ_CTRL_IRQ_NO_OFS   8'h10
`define IRQ_CTRL_ALL_EN_OFS   8'h14
`define IRQ_CTRL_TEST_OFS     8'h18
`define IRQ_CTRL_TEST_IRQ_OFS 8'h1C

`define IRQ_CTRL_MASK_RESVAL     '0
`define IRQ_CTRL_ALL_EN_RESVAL   1'b0
`define IRQ_CTRL_TEST_RESVAL     1'b0
`define IRQ_CTRL_TEST_IRQ_RESVAL '0

`endif
